// File: design/console_bus_sync.sv
module console_bus_sync #(
  parameter int SYNC_STAGES = 2
) (
  input  logic                                   clk_ppu_21_47,
  input  logic                                   reset_nes,
  input  logic                                   joypad_strobe,
  input  logic [controller_pkg::NUM_PORTS-1:0]   joypad_clock,
  port_if.source                                 port1,
  port_if.source                                 port2
);

  localparam int NP = controller_pkg::NUM_PORTS;

  // bit 0 is the strobe, bits NP:1 the port clocks
  logic [NP:0]   sync_q [SYNC_STAGES];
  logic [NP-1:0] clk_prev_q;
  logic [NP-1:0] fall_q;
  logic [NP:0]   sync_out;

  if (SYNC_STAGES < 2) begin : g_depth_check
    $error("console_bus_sync needs at least two synchronizer stages");
  end

  assign sync_out = sync_q[SYNC_STAGES-1];

  always_ff @(posedge clk_ppu_21_47) begin
    if (reset_nes) begin
      for (int i = 0; i < SYNC_STAGES; i++) begin
        sync_q[i] <= '0;
      end
      clk_prev_q <= '0;
      fall_q     <= '0;
    end else begin
      sync_q[0] <= {joypad_clock, joypad_strobe};
      for (int i = 1; i < SYNC_STAGES; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
      clk_prev_q <= sync_out[NP:1];
      // high last cycle, low now
      fall_q     <= clk_prev_q & ~sync_out[NP:1];
    end
  end

  assign port1.load  = sync_out[0];
  assign port2.load  = sync_out[0];
  assign port1.shift = fall_q[0];
  assign port2.shift = fall_q[1];

  // a held-low port clock must not keep shifting the frame
  assert property (@(posedge clk_ppu_21_47) disable iff (reset_nes)
    port1.shift |=> !port1.shift);
  assert property (@(posedge clk_ppu_21_47) disable iff (reset_nes)
    port2.shift |=> !port2.shift);

endmodule

// File: design/controller_pkg.sv
package controller_pkg;

  // number of console controller ports
  localparam int NUM_PORTS = 2;

  // bits shifted out per port before the line goes to zero
  localparam int FRAME_BITS = 24;

  // one player's buttons
  // bit 0 is A and leaves the port first
  typedef struct packed {
    logic right;
    logic left;
    logic down;
    logic up;
    logic start;
    logic select;
    logic b;
    logic a;
  } button_t;

  // serial frame for one port, bit 0 goes out first
  typedef logic [FRAME_BITS-1:0] frame_t;

  // four-player adapter id bytes, sent after both players
  localparam logic [7:0] TAP_SIG_PORT1 = 8'h08;
  localparam logic [7:0] TAP_SIG_PORT2 = 8'h04;

  // a standard pad reads ones after its 8 buttons
  localparam logic [15:0] NO_TAP_FILL = 16'hFFFF;

endpackage

// File: design/frame_builder.sv
module frame_builder (
  input  logic                    clk_ppu_21_47,
  input  logic                    reset_nes,
  input  controller_pkg::button_t p1_buttons,
  input  controller_pkg::button_t p2_buttons,
  input  controller_pkg::button_t p3_buttons,
  input  controller_pkg::button_t p4_buttons,
  input  logic                    multitap_enabled,
  port_if.source                  port1,
  port_if.source                  port2
);

  controller_pkg::button_t p1_q;
  controller_pkg::button_t p2_q;
  controller_pkg::button_t p3_q;
  controller_pkg::button_t p4_q;
  logic                    tap_q;

  controller_pkg::frame_t  frame1;
  controller_pkg::frame_t  frame2;

  // button levels, sampled every cycle
  always_ff @(posedge clk_ppu_21_47) begin
    p1_q <= p1_buttons;
    p2_q <= p2_buttons;
    p3_q <= p3_buttons;
    p4_q <= p4_buttons;
  end

  always_ff @(posedge clk_ppu_21_47) begin
    if (reset_nes) begin
      tap_q <= 1'b0;
    end else begin
      tap_q <= multitap_enabled;
    end
  end

  // low byte leaves first, so the near player sits at bits 7:0
  always_comb begin
    if (tap_q) begin
      // players 1 and 3 on port 1, players 2 and 4 on port 2,
      // each followed by the adapter id byte
      frame1 = {controller_pkg::TAP_SIG_PORT1, p3_q, p1_q};
      frame2 = {controller_pkg::TAP_SIG_PORT2, p4_q, p2_q};
    end else begin
      frame1 = {controller_pkg::NO_TAP_FILL, p1_q};
      frame2 = {controller_pkg::NO_TAP_FILL, p2_q};
    end
  end

  assign port1.frame = frame1;
  assign port2.frame = frame2;

endmodule

// File: design/nes_controller_ports.sv
module nes_controller_ports #(
  parameter int SYNC_STAGES = 2
) (
  input  logic                                 clk_ppu_21_47,
  input  logic                                 reset_nes,
  input  controller_pkg::button_t              p1_buttons,
  input  controller_pkg::button_t              p2_buttons,
  input  controller_pkg::button_t              p3_buttons,
  input  controller_pkg::button_t              p4_buttons,
  input  logic                                 multitap_enabled,
  input  logic                                 joypad_strobe,
  input  logic [controller_pkg::NUM_PORTS-1:0] joypad_clock,
  output logic                                 joypad1_data,
  output logic                                 joypad2_data
);

  // one bus per console port
  port_if port1_bus ();
  port_if port2_bus ();

  // strobe and port clocks come from the cpu domain
  console_bus_sync #(
    .SYNC_STAGES(SYNC_STAGES)
  ) console_bus_sync_inst (
    .clk_ppu_21_47(clk_ppu_21_47),
    .reset_nes    (reset_nes),
    .joypad_strobe(joypad_strobe),
    .joypad_clock (joypad_clock),
    .port1        (port1_bus),
    .port2        (port2_bus)
  );

  frame_builder frame_builder_inst (
    .clk_ppu_21_47   (clk_ppu_21_47),
    .reset_nes       (reset_nes),
    .p1_buttons      (p1_buttons),
    .p2_buttons      (p2_buttons),
    .p3_buttons      (p3_buttons),
    .p4_buttons      (p4_buttons),
    .multitap_enabled(multitap_enabled),
    .port1           (port1_bus),
    .port2           (port2_bus)
  );

  serial_shifter port1_shifter_inst (
    .clk_ppu_21_47(clk_ppu_21_47),
    .reset_nes    (reset_nes),
    .port         (port1_bus)
  );

  serial_shifter port2_shifter_inst (
    .clk_ppu_21_47(clk_ppu_21_47),
    .reset_nes    (reset_nes),
    .port         (port2_bus)
  );

  assign joypad1_data = port1_bus.data;
  assign joypad2_data = port2_bus.data;

endmodule

// File: design/port_if.sv
interface port_if;

  // frame assembled from the player buttons
  controller_pkg::frame_t frame;

  // synchronized console strobe, same on both ports
  logic load;

  // one-cycle pulse on a falling port clock
  logic shift;

  // serial bit back to the console
  logic data;

  // frame builder drives frame, bus sync drives load and shift
  modport source (
    output frame,
    output load,
    output shift
  );

  modport shifter (
    input  frame,
    input  load,
    input  shift,
    output data
  );

endinterface

// File: design/serial_shifter.sv
module serial_shifter (
  input  logic     clk_ppu_21_47,
  input  logic     reset_nes,
  port_if.shifter  port
);

  localparam int FB = controller_pkg::FRAME_BITS;

  controller_pkg::frame_t frame_q;

  // shift beats load, so a clock edge during strobe still moves the frame
  // for one cycle before the reload catches up
  always_ff @(posedge clk_ppu_21_47) begin
    if (reset_nes) begin
      frame_q <= '0;
    end else if (port.shift) begin
      // zero fills from the top, read past the end gives 0
      frame_q <= {1'b0, frame_q[FB-1:1]};
    end else if (port.load) begin
      frame_q <= port.frame;
    end
  end

  // console samples bit 0
  assign port.data = frame_q[0];

  // builder output must be settled before the first strobe lands
  assert property (@(posedge clk_ppu_21_47) disable iff (reset_nes)
    !$isunknown(frame_q));

endmodule

// File: run_sim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module tb_nes_controller_ports -f sim.f -o tb_sim

status=0
./obj_dir/tb_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q '>>> FAIL' sim.log; then
  echo "simulation reported failure"
  exit 1
fi
if [ "$status" -ne 0 ]; then
  echo "simulator exited with status $status"
  exit 1
fi
echo "simulation finished without failure"

// File: sim.f
design/controller_pkg.sv
design/port_if.sv
design/console_bus_sync.sv
design/frame_builder.sv
design/serial_shifter.sv
design/nes_controller_ports.sv
test/tb_clock.sv
test/tb_nes_controller_ports.sv

// File: test/controller_vectors.txt
// p1 p2 p3 p4 buttons then multitap then expected port 1 and port 2 streams in hex
// stream bit 0 is read first and button bit 0 is A

// standard pads
00 00 00 00 0 FFFF00 FFFF00
FF FF FF FF 0 FFFFFF FFFFFF
01 02 04 08 0 FFFF01 FFFF02
80 40 20 10 0 FFFF80 FFFF40
A5 5A 3C C3 0 FFFFA5 FFFF5A
12 34 56 78 0 FFFF12 FFFF34
C0 03 99 66 0 FFFFC0 FFFF03
55 AA 00 00 0 FFFF55 FFFFAA
FE 7F EF F7 0 FFFFFE FFFF7F
9C 2B 00 00 0 FFFF9C FFFF2B

// four-player adapter
00 00 00 00 1 080000 040000
FF FF FF FF 1 08FFFF 04FFFF
01 02 04 08 1 080401 040802
80 40 20 10 1 082080 041040
A5 5A 3C C3 1 083CA5 04C35A
12 34 56 78 1 085612 047834
0F F0 E7 7E 1 08E70F 047EF0
3A B7 4D D2 1 084D3A 04D2B7
6E 91 00 FF 1 08006E 04FF91
01 00 00 80 1 080001 048000
00 80 01 00 1 080100 040080
5B 6C 7D 8E 1 087D5B 048E6C
02 04 08 10 1 080802 041004
00 FF FF 00 1 08FF00 0400FF

// File: test/tb_clock.sv
module tb_clock #(
  parameter int RESET_CYCLES = 4
) (
  output logic clk_ppu_21_47,
  output logic reset_nes
);
  timeunit 1ns;
  timeprecision 1ps;

  // 100 ns period
  localparam time HALF_PERIOD = 50ns;
  localparam time DRIVE_DELAY = 5ns;

  initial begin
    clk_ppu_21_47 = 1'b0;
    forever #HALF_PERIOD clk_ppu_21_47 = ~clk_ppu_21_47;
  end

  // released just after a rising edge, like every other input
  initial begin
    reset_nes = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_ppu_21_47);
    #DRIVE_DELAY;
    reset_nes = 1'b0;
  end

endmodule

// File: test/tb_nes_controller_ports.sv
module tb_nes_controller_ports;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int SYNC_STAGES  = 2;
  localparam int NUM_PORTS    = controller_pkg::NUM_PORTS;
  localparam int FRAME_BITS   = controller_pkg::FRAME_BITS;
  // two reads past the frame end must come back as zero
  localparam int STREAM_BITS  = FRAME_BITS + 2;
  localparam int HOLD_CYCLES  = 8;
  localparam int RESET_CYCLES = 4;
  // clock pulses per port while the strobe stays high
  localparam int HELD_PULSES  = 3;
  // p1 p2 p3 p4 tap stream1 stream2
  localparam int FIELDS       = 7;
  localparam int MAX_VECTORS  = 64;
  localparam int MAX_WORDS    = MAX_VECTORS * FIELDS;
  localparam int MARGIN       = 200;
  localparam time DRIVE_DELAY = 5ns;
  // wider than any value in the file, marks unused entries
  localparam logic [31:0] EMPTY_WORD = 32'hFFFF_FFFF;

  logic                    clk_ppu_21_47;
  logic                    reset_nes;
  controller_pkg::button_t p1_buttons;
  controller_pkg::button_t p2_buttons;
  controller_pkg::button_t p3_buttons;
  controller_pkg::button_t p4_buttons;
  logic                    multitap_enabled;
  logic                    joypad_strobe;
  logic [NUM_PORTS-1:0]    joypad_clock;
  logic                    joypad1_data;
  logic                    joypad2_data;

  logic [31:0] vec_mem [MAX_WORDS];
  int          num_vectors;
  int          vec_idx;
  int          value_errors;
  int          other_errors;
  int          cycle_limit;
  int          cycle_count = 0;

  tb_clock #(
    .RESET_CYCLES(RESET_CYCLES)
  ) tb_clock_inst (
    .clk_ppu_21_47(clk_ppu_21_47),
    .reset_nes    (reset_nes)
  );

  nes_controller_ports #(
    .SYNC_STAGES(SYNC_STAGES)
  ) nes_controller_ports_inst (
    .clk_ppu_21_47   (clk_ppu_21_47),
    .reset_nes       (reset_nes),
    .p1_buttons      (p1_buttons),
    .p2_buttons      (p2_buttons),
    .p3_buttons      (p3_buttons),
    .p4_buttons      (p4_buttons),
    .multitap_enabled(multitap_enabled),
    .joypad_strobe   (joypad_strobe),
    .joypad_clock    (joypad_clock),
    .joypad1_data    (joypad1_data),
    .joypad2_data    (joypad2_data)
  );

  // step n rising edges, then on to the drive point
  task automatic advance_cycles(input int n);
    repeat (n) @(posedge clk_ppu_21_47);
    #DRIVE_DELAY;
  endtask

  task automatic check_value(
    input string name,
    input int    bit_idx,
    input logic  expected,
    input logic  actual
  );
    assert (actual === expected) else begin
      value_errors++;
      $display("ERR %s vector %0d bit %0d expected %h actual %h",
               name, vec_idx, bit_idx, expected, actual);
    end
  endtask

  function automatic logic port_data(input logic port_sel);
    return port_sel ? joypad2_data : joypad1_data;
  endfunction

  function automatic string port_name(input logic port_sel);
    return port_sel ? "joypad2_data" : "joypad1_data";
  endfunction

  // button A sits at bit 0 of the player on each port
  function automatic logic player_a_bit(input logic port_sel);
    return port_sel ? p2_buttons.a : p1_buttons.a;
  endfunction

  task automatic strobe_frames();
    joypad_strobe = 1'b1;
    advance_cycles(HOLD_CYCLES);
    joypad_strobe = 1'b0;
    advance_cycles(HOLD_CYCLES);
  endtask

  task automatic pulse_port_clock(input logic port_sel);
    joypad_clock[port_sel] = 1'b1;
    advance_cycles(HOLD_CYCLES);
    joypad_clock[port_sel] = 1'b0;
    advance_cycles(HOLD_CYCLES);
  endtask

  task automatic load_vectors();
    int words;
    words = 0;
    for (int i = 0; i < MAX_WORDS; i++) begin
      vec_mem[i] = EMPTY_WORD;
    end
    $readmemh("test/controller_vectors.txt", vec_mem);
    while (words < MAX_WORDS && vec_mem[words] != EMPTY_WORD) begin
      words++;
    end
    assert (words % FIELDS == 0) else begin
      other_errors++;
      $display("vector file has %0d values, which do not fill whole lines", words);
    end
    num_vectors = words / FIELDS;
    assert (num_vectors > 0) else begin
      other_errors++;
      $display("no test vectors could be read from the vector file");
    end
    // full reads of both ports, the strobe before each read,
    // the held-strobe pass and the reset phase
    cycle_limit = num_vectors * NUM_PORTS * STREAM_BITS * 2 * HOLD_CYCLES
                + num_vectors * NUM_PORTS * 2 * HOLD_CYCLES
                + num_vectors * (2 + NUM_PORTS * HELD_PULSES * 2) * HOLD_CYCLES
                + RESET_CYCLES + HOLD_CYCLES + MARGIN;
  endtask

  task automatic apply_vector(input int v);
    int base;
    base = v * FIELDS;
    p1_buttons       = vec_mem[base][7:0];
    p2_buttons       = vec_mem[base + 1][7:0];
    p3_buttons       = vec_mem[base + 2][7:0];
    p4_buttons       = vec_mem[base + 3][7:0];
    multitap_enabled = vec_mem[base + 4][0];
  endtask

  // frame keeps reloading, so every pulse still shows button A
  task automatic check_held_strobe();
    joypad_strobe = 1'b1;
    advance_cycles(HOLD_CYCLES);
    for (int p = 0; p < NUM_PORTS; p++) begin
      for (int k = 0; k < HELD_PULSES; k++) begin
        pulse_port_clock(p[0]);
        check_value(port_name(p[0]), k, player_a_bit(p[0]), port_data(p[0]));
      end
    end
    joypad_strobe = 1'b0;
    advance_cycles(HOLD_CYCLES);
  endtask

  task automatic read_port_stream(
    input logic                  port_sel,
    input logic [FRAME_BITS-1:0] stream
  );
    logic [STREAM_BITS-1:0] pending;
    pending = {2'b00, stream};
    strobe_frames();
    for (int i = 0; i < STREAM_BITS; i++) begin
      check_value(port_name(port_sel), i, pending[0], port_data(port_sel));
      // other port was never clocked
      check_value(port_name(~port_sel), i, player_a_bit(~port_sel), port_data(~port_sel));
      pulse_port_clock(port_sel);
      pending = pending >> 1;
    end
  endtask

  always @(posedge clk_ppu_21_47) begin
    cycle_count <= cycle_count + 1;
  end

  initial begin : watchdog
    wait (cycle_limit > 0);
    wait (cycle_count > cycle_limit);
    $display("timeout after %0d clock cycles, the test sequence did not finish", cycle_limit);
    $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    $display(">>> FAIL");
    $finish;
  end

  initial begin
    p1_buttons       = '0;
    p2_buttons       = '0;
    p3_buttons       = '0;
    p4_buttons       = '0;
    multitap_enabled = 1'b0;
    joypad_strobe    = 1'b0;
    joypad_clock     = '0;
    value_errors     = 0;
    other_errors     = 0;
    num_vectors      = 0;
    cycle_limit      = 0;
    vec_idx          = -1;

    load_vectors();

    @(negedge reset_nes);
    advance_cycles(HOLD_CYCLES);
    // outputs stay low until the first strobe
    check_value("joypad1_data", 0, 1'b0, joypad1_data);
    check_value("joypad2_data", 0, 1'b0, joypad2_data);

    for (vec_idx = 0; vec_idx < num_vectors; vec_idx++) begin
      apply_vector(vec_idx);
      check_held_strobe();
      read_port_stream(1'b0, vec_mem[vec_idx * FIELDS + 5][FRAME_BITS-1:0]);
      read_port_stream(1'b1, vec_mem[vec_idx * FIELDS + 6][FRAME_BITS-1:0]);
    end

    $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    if (value_errors + other_errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule
